// File: expipe_pkg.sv
// ============================
// Shared types for the issue stage
// Packet layout is fixed by XLEN and ILEN
// Exception codes follow the RISC-V mcause encoding
// Only the opcodes listed in opcode_t are decoded
// ============================
`default_nettype none

package expipe_pkg;

    // Data and address width
    localparam int unsigned XLEN = 32;
    // Instruction width
    localparam int unsigned ILEN = 32;
    // Default issue queue depth
    localparam int unsigned IQ_DEPTH_DEF = 4;

    // Exception causes carried with each instruction
    typedef enum logic [3:0] {
        EXC_I_ADDR_MISALIGNED = 4'd0,
        EXC_I_ACCESS_FAULT    = 4'd1,
        EXC_ILLEGAL_INSTR     = 4'd2,
        EXC_BREAKPOINT        = 4'd3,
        EXC_I_PAGE_FAULT      = 4'd12,
        EXC_NONE              = 4'd15
    } except_code_t;

    // Destination of an issued instruction
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_BU  = 2'd1,
        UNIT_LSU = 2'd2,
        UNIT_EXC = 2'd3
    } issue_unit_t;

    // RISC-V major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    // Packet as delivered by the fetch unit
    typedef struct packed {
        logic [XLEN-1:0] curr_pc;
        logic [ILEN-1:0] instruction;
        logic [XLEN-1:0] pred_target;
        logic            pred_taken;
        logic            except_raised;
        except_code_t    except_code;
    } fetch_pkt_t;

    // One slot of the issue queue
    typedef struct packed {
        logic       valid;
        fetch_pkt_t pkt;
    } iq_entry_t;

    // Packet offered to the execution units
    // except_code may differ from the fetched one
    typedef struct packed {
        logic [XLEN-1:0] curr_pc;
        logic [ILEN-1:0] instruction;
        logic [XLEN-1:0] pred_target;
        logic            pred_taken;
        logic            except_raised;
        except_code_t    except_code;
    } issue_pkt_t;

endpackage

`default_nettype wire

// File: iq_storage.sv
// ============================
// Entry array of the issue queue
// IQ_DEPTH must be at least 2
// Head read is combinational
// Write wins over a head clear on the same slot
// Payload registers are not reset
// ============================
`timescale 1ns/1ps
`default_nettype none

module iq_storage
    import expipe_pkg::*;
#(
    parameter int unsigned IQ_DEPTH = IQ_DEPTH_DEF
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        flush_i,

    // Write port at the tail
    input  logic                        wr_en_i,
    input  logic [$clog2(IQ_DEPTH)-1:0] wr_idx_i,
    input  fetch_pkt_t                  wr_pkt_i,

    // Read port at the head
    input  logic                        rd_en_i,
    input  logic [$clog2(IQ_DEPTH)-1:0] rd_idx_i,
    output iq_entry_t                   rd_entry_o
);

    // Valid bit per slot
    logic [IQ_DEPTH-1:0] valid_q;

    // Stored packets
    fetch_pkt_t          pkt_q [IQ_DEPTH];

    // Valid bits
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // Drop every pending instruction
            valid_q <= '0;
        end else begin
            // Head leaves the queue
            if (rd_en_i) begin
                valid_q[rd_idx_i] <= 1'b0;
            end
            // New entry arrives, may reuse the freed head slot when full
            if (wr_en_i) begin
                valid_q[wr_idx_i] <= 1'b1;
            end
        end
    end

    // Packet payload
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            pkt_q[wr_idx_i] <= wr_pkt_i;
        end
    end

    // Fall-through head read
    always_comb begin
        rd_entry_o.valid = valid_q[rd_idx_i];
        rd_entry_o.pkt   = pkt_q[rd_idx_i];
    end

endmodule

`default_nettype wire

// File: issue_queue.sv
// ============================
// In-order issue queue, valid/ready on both sides
// IQ_DEPTH must be at least 2
// When full, a push is accepted only together with a pop
// Flush empties the queue at the next edge
// ============================
`timescale 1ns/1ps
`default_nettype none

module issue_queue
    import expipe_pkg::*;
#(
    parameter int unsigned IQ_DEPTH = IQ_DEPTH_DEF
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       flush_i,

    // Fetch side
    input  logic       fetch_valid_i,
    input  fetch_pkt_t fetch_pkt_i,
    output logic       fetch_ready_o,

    // Issue side
    input  logic       issue_ready_i,
    output logic       issue_valid_o,
    output fetch_pkt_t issue_pkt_o
);

    localparam int unsigned IDX_W = $clog2(IQ_DEPTH);
    localparam int unsigned CNT_W = $clog2(IQ_DEPTH + 1);

    // Pointers and occupancy
    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // Handshake events
    logic             push;
    logic             pop;
    logic             full;
    iq_entry_t        head_entry;

    assign full = (count_q == CNT_W'(IQ_DEPTH));

    // Head is offered only while it holds a live entry
    assign issue_valid_o = head_entry.valid & ~flush_i;
    assign issue_pkt_o   = head_entry.pkt;
    assign pop           = issue_valid_o & issue_ready_i;

    // A full queue still accepts when the head leaves in the same cycle
    assign fetch_ready_o = ~flush_i & (~full | pop);
    assign push          = fetch_valid_i & fetch_ready_o;

    // Pointer and count update, same edge as the handshakes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // Mod-IQ_DEPTH wrap
            if (pop) begin
                head_q <= (head_q == IDX_W'(IQ_DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            if (push) begin
                tail_q <= (tail_q == IDX_W'(IQ_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    iq_storage #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq_storage (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .wr_en_i    (push),
        .wr_idx_i   (tail_q),
        .wr_pkt_i   (fetch_pkt_i),
        .rd_en_i    (pop),
        .rd_idx_i   (head_q),
        .rd_entry_o (head_entry)
    );

endmodule

`default_nettype wire

// File: issue_dispatch.sv
// ============================
// Routes the queue head to one execution unit
// Purely combinational
// Fetch exceptions take priority over decode
// Unknown opcodes become illegal instruction
// ============================
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch
    import expipe_pkg::*;
(
    // Queue side
    input  logic       iq_valid_i,
    input  fetch_pkt_t iq_pkt_i,
    output logic       iq_ready_o,

    // Unit readies
    input  logic       alu_ready_i,
    input  logic       bu_ready_i,
    input  logic       lsu_ready_i,
    input  logic       exc_ready_i,

    // Unit valids, one hot at most
    output logic       alu_valid_o,
    output logic       bu_valid_o,
    output logic       lsu_valid_o,
    output logic       exc_valid_o,

    // Packet shared by all units
    output issue_pkt_t issue_pkt_o
);

    issue_unit_t  unit_sel;
    except_code_t code_sel;

    // Destination and exception code
    always_comb begin
        unit_sel = UNIT_EXC;
        code_sel = EXC_ILLEGAL_INSTR;
        if (iq_pkt_i.except_raised) begin
            // Keep the cause reported by fetch
            code_sel = iq_pkt_i.except_code;
        end else begin
            case (opcode_t'(iq_pkt_i.instruction[6:0]))
                OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                    unit_sel = UNIT_ALU;
                    code_sel = EXC_NONE;
                end
                OPC_BRANCH, OPC_JAL, OPC_JALR: begin
                    unit_sel = UNIT_BU;
                    code_sel = EXC_NONE;
                end
                OPC_LOAD, OPC_STORE: begin
                    unit_sel = UNIT_LSU;
                    code_sel = EXC_NONE;
                end
                // Anything else goes to commit as illegal
                default: begin
                    unit_sel = UNIT_EXC;
                    code_sel = EXC_ILLEGAL_INSTR;
                end
            endcase
        end
    end

    // Only the selected unit sees valid
    assign alu_valid_o = iq_valid_i & (unit_sel == UNIT_ALU);
    assign bu_valid_o  = iq_valid_i & (unit_sel == UNIT_BU);
    assign lsu_valid_o = iq_valid_i & (unit_sel == UNIT_LSU);
    assign exc_valid_o = iq_valid_i & (unit_sel == UNIT_EXC);

    // Ready of the selected unit back to the queue
    always_comb begin
        case (unit_sel)
            UNIT_ALU: iq_ready_o = alu_ready_i;
            UNIT_BU:  iq_ready_o = bu_ready_i;
            UNIT_LSU: iq_ready_o = lsu_ready_i;
            default:  iq_ready_o = exc_ready_i;
        endcase
    end

    // Payload passes through, code rewritten
    always_comb begin
        issue_pkt_o.curr_pc       = iq_pkt_i.curr_pc;
        issue_pkt_o.instruction   = iq_pkt_i.instruction;
        issue_pkt_o.pred_target   = iq_pkt_i.pred_target;
        issue_pkt_o.pred_taken    = iq_pkt_i.pred_taken;
        issue_pkt_o.except_raised = iq_pkt_i.except_raised;
        issue_pkt_o.except_code   = code_sel;
    end

endmodule

`default_nettype wire

// File: issue_stage.sv
// ============================
// Issue stage top level
// IQ_DEPTH must be at least 2
// Unit valids are low while flush_i is high
// ============================
`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import expipe_pkg::*;
#(
    parameter int unsigned IQ_DEPTH = IQ_DEPTH_DEF
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       flush_i,

    // Fetch side
    input  logic       fetch_valid_i,
    input  fetch_pkt_t fetch_pkt_i,
    output logic       fetch_ready_o,

    // Execution units
    input  logic       alu_ready_i,
    input  logic       bu_ready_i,
    input  logic       lsu_ready_i,
    input  logic       exc_ready_i,
    output logic       alu_valid_o,
    output logic       bu_valid_o,
    output logic       lsu_valid_o,
    output logic       exc_valid_o,
    output issue_pkt_t issue_pkt_o
);

    // Queue head toward dispatch
    logic       iq_valid;
    logic       iq_ready;
    fetch_pkt_t iq_pkt;

    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_issue_queue (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pkt_i   (fetch_pkt_i),
        .fetch_ready_o (fetch_ready_o),
        .issue_ready_i (iq_ready),
        .issue_valid_o (iq_valid),
        .issue_pkt_o   (iq_pkt)
    );

    issue_dispatch u_issue_dispatch (
        .iq_valid_i  (iq_valid),
        .iq_pkt_i    (iq_pkt),
        .iq_ready_o  (iq_ready),
        .alu_ready_i (alu_ready_i),
        .bu_ready_i  (bu_ready_i),
        .lsu_ready_i (lsu_ready_i),
        .exc_ready_i (exc_ready_i),
        .alu_valid_o (alu_valid_o),
        .bu_valid_o  (bu_valid_o),
        .lsu_valid_o (lsu_valid_o),
        .exc_valid_o (exc_valid_o),
        .issue_pkt_o (issue_pkt_o)
    );

endmodule

`default_nettype wire

// File: tb_issue_stage.sv
// ==============================
// Testbench for the issue stage
// Packets and expected results come from issue_testdata.txt
// Unit readies are random with a fixed seed
// Inputs change on the rising edge and outputs are sampled on the falling edge
// The run stops at the first mismatch
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage
    import expipe_pkg::*;
();

    localparam int MAX_PKT   = 64;
    localparam int MAX_WORDS = MAX_PKT * 8;
    localparam int TIMEOUT   = 2000;

    logic       clk_i;
    logic       arst_n_i;
    logic       flush_i;
    logic       fetch_valid_i;
    fetch_pkt_t fetch_pkt_i;
    logic       fetch_ready_o;
    logic       alu_ready_i;
    logic       bu_ready_i;
    logic       lsu_ready_i;
    logic       exc_ready_i;
    logic       alu_valid_o;
    logic       bu_valid_o;
    logic       lsu_valid_o;
    logic       exc_valid_o;
    issue_pkt_t issue_pkt_o;

    // Raw words from the file with eight per packet
    logic [31:0] tdata [MAX_WORDS];

    // Packets from the file with their expected results
    fetch_pkt_t  src_pkt[$];
    issue_pkt_t  exp_pkt[$];
    issue_unit_t exp_unit[$];

    // Accepted by the DUT and not yet issued with the oldest first
    issue_pkt_t  pend_pkt[$];
    issue_unit_t pend_unit[$];

    integer seed;
    int     send_idx;
    int     send_end;
    int     accept_cnt;
    logic   hold_ready;
    logic   flush_req;

    issue_stage #(
        .IQ_DEPTH (4)
    ) i_issue_stage (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pkt_i   (fetch_pkt_i),
        .fetch_ready_o (fetch_ready_o),
        .alu_ready_i   (alu_ready_i),
        .bu_ready_i    (bu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .exc_ready_i   (exc_ready_i),
        .alu_valid_o   (alu_valid_o),
        .bu_valid_o    (bu_valid_o),
        .lsu_valid_o   (lsu_valid_o),
        .exc_valid_o   (exc_valid_o),
        .issue_pkt_o   (issue_pkt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_pkt(input issue_pkt_t got, input issue_pkt_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR issue_pkt_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_unit(input issue_unit_t got, input issue_unit_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR issued unit got %h expected %h", got, exp));
        end
    endtask

    task automatic check_ready(input logic exp);
        if (fetch_ready_o !== exp) begin
            abort_run($sformatf("ERR fetch_ready_o got %h expected %h", fetch_ready_o, exp));
        end
    endtask

    // Unused words stay all ones, so the first such pc ends the list
    task automatic load_packets();
        logic [8:0] wa;
        fetch_pkt_t f;
        issue_pkt_t e;
        tdata = '{default: 32'hffff_ffff};
        $readmemh("issue_testdata.txt", tdata);
        wa = '0;
        while (tdata[wa] != 32'hffff_ffff && src_pkt.size() < MAX_PKT) begin
            f.curr_pc       = tdata[wa];
            f.instruction   = tdata[wa + 9'd1];
            f.pred_target   = tdata[wa + 9'd2];
            f.pred_taken    = tdata[wa + 9'd3][0];
            f.except_raised = tdata[wa + 9'd4][0];
            f.except_code   = except_code_t'(tdata[wa + 9'd5][3:0]);
            // Same payload on the unit side with the code from the last column
            e             = issue_pkt_t'(f);
            e.except_code = except_code_t'(tdata[wa + 9'd7][3:0]);
            src_pkt.push_back(f);
            exp_pkt.push_back(e);
            exp_unit.push_back(issue_unit_t'(tdata[wa + 9'd6][1:0]));
            wa = wa + 9'd8;
        end
        if (src_pkt.size() < 16) begin
            abort_run("The testdata file holds fewer than 16 packets");
        end
    endtask

    // One clock that drives at the rising edge and observes at the falling edge
    task automatic run_cycle();
        logic [31:0] rnd;
        int          nvalid;
        issue_unit_t got_unit;
        logic        sel_ready;
        @(posedge clk_i);
        rnd = $random(seed);
        flush_i       <= flush_req;
        fetch_valid_i <= (send_idx < send_end);
        if (send_idx < send_end) begin
            fetch_pkt_i <= src_pkt[send_idx];
        end
        alu_ready_i <= rnd[0] & ~hold_ready;
        bu_ready_i  <= rnd[1] & ~hold_ready;
        lsu_ready_i <= rnd[2] & ~hold_ready;
        exc_ready_i <= rnd[3] & ~hold_ready;
        @(negedge clk_i);
        nvalid = $countones({alu_valid_o, bu_valid_o, lsu_valid_o, exc_valid_o});
        if (flush_i) begin
            if (nvalid != 0) begin
                abort_run("A unit valid is high while flush is high");
            end
            check_ready(1'b0);
        end
        if (nvalid > 1) begin
            abort_run("More than one unit valid is high");
        end
        if (nvalid == 1) begin
            if (pend_pkt.size() == 0) begin
                abort_run("A unit valid is high with no packet pending");
            end
            // Destination as seen from the valids
            got_unit  = UNIT_EXC;
            sel_ready = exc_ready_i;
            if (alu_valid_o) begin
                got_unit  = UNIT_ALU;
                sel_ready = alu_ready_i;
            end else if (bu_valid_o) begin
                got_unit  = UNIT_BU;
                sel_ready = bu_ready_i;
            end else if (lsu_valid_o) begin
                got_unit  = UNIT_LSU;
                sel_ready = lsu_ready_i;
            end
            check_unit(got_unit, pend_unit[0]);
            check_pkt(issue_pkt_o, pend_pkt[0]);
            // Leaves at the coming edge
            if (sel_ready) begin
                void'(pend_pkt.pop_front());
                void'(pend_unit.pop_front());
            end
        end
        // Enters the queue at the coming edge
        if (fetch_valid_i && fetch_ready_o) begin
            pend_pkt.push_back(exp_pkt[send_idx]);
            pend_unit.push_back(exp_unit[send_idx]);
            send_idx++;
            accept_cnt++;
        end
    endtask

    task automatic wait_accepted(input int n);
        int start;
        int cycles;
        start  = accept_cnt;
        cycles = 0;
        while (accept_cnt - start < n) begin
            if (cycles == TIMEOUT) begin
                abort_run("Timed out waiting for fetch packets to be accepted");
            end
            run_cycle();
            cycles++;
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (send_idx < send_end || pend_pkt.size() != 0) begin
            if (cycles == TIMEOUT) begin
                abort_run("Timed out waiting for the queue to drain");
            end
            run_cycle();
            cycles++;
        end
    endtask

    initial begin
        seed          = 32'h11e6;
        arst_n_i      <= 1'b0;
        flush_i       <= 1'b0;
        fetch_valid_i <= 1'b0;
        fetch_pkt_i   <= '0;
        alu_ready_i   <= 1'b0;
        bu_ready_i    <= 1'b0;
        lsu_ready_i   <= 1'b0;
        exc_ready_i   <= 1'b0;
        send_idx      = 0;
        send_end      = 0;
        accept_cnt    = 0;
        hold_ready    = 1'b1;
        flush_req     = 1'b0;
        load_packets();
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        // Empty queue after reset
        if ({alu_valid_o, bu_valid_o, lsu_valid_o, exc_valid_o} != 4'b0000) begin
            abort_run("A unit valid is high after reset");
        end
        check_ready(1'b1);

        // Whole file with random readies
        hold_ready = 1'b0;
        send_idx   = 0;
        send_end   = src_pkt.size();
        wait_drained();

        // Fill to depth with all readies low while a fifth packet waits
        hold_ready = 1'b1;
        send_idx   = 0;
        send_end   = 5;
        wait_accepted(4);
        repeat (3) begin
            run_cycle();
            check_ready(1'b0);
        end
        hold_ready = 1'b0;
        wait_drained();

        // Three packets dropped by a one cycle flush
        hold_ready = 1'b1;
        send_idx   = 0;
        send_end   = 3;
        wait_accepted(3);
        flush_req = 1'b1;
        run_cycle();
        flush_req = 1'b0;
        pend_pkt.delete();
        pend_unit.delete();
        hold_ready = 1'b0;
        repeat (10) run_cycle();

        // Normal traffic after the flush
        send_idx = 8;
        send_end = 16;
        wait_drained();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: issue_testdata.txt
// pc instruction pred_target pred_taken except_raised except_code exp_unit exp_code
// exp_unit is 0 ALU, 1 branch, 2 load/store, 3 exception
00001000 003100b3 00001004 0 0 f 0 f
00001004 00500093 00001008 0 0 f 0 f
00001008 123450b7 0000100c 0 0 f 0 f
0000100c 00001117 00001010 0 0 f 0 f
00001010 00208463 00001018 1 0 f 1 f
00001014 008000ef 0000101c 1 0 f 1 f
00001018 00008067 00002000 1 0 f 1 f
0000101c 0000a103 00001020 0 0 f 2 f
00001020 0020a023 00001024 0 0 f 2 f
00001024 0000000b 00001028 0 0 f 3 2
00001028 00000073 0000102c 0 0 f 3 2
0000102c 00000000 00001030 0 1 1 3 1
00001030 003100b3 00001034 0 1 c 3 c
00001032 0000a103 00001036 0 1 0 3 0
00001036 00100073 0000103a 0 1 3 3 3
0000103a 003100b3 0000103e 0 0 0 0 f
0000103e 00208463 00003000 1 0 2 1 f
00001040 40208133 00001044 0 0 f 0 f
00001044 fff00193 00001048 0 0 f 0 f
00001048 00412203 0000104c 0 0 f 2 f
0000104c 00412223 00001050 0 0 f 2 f
00001050 fe209ee3 00001040 1 0 f 1 f
00001054 0000005b 00001058 0 0 f 3 2
00001058 ffffffff 0000105c 0 0 f 3 2
0000105c 00000000 00001060 0 0 f 3 2
00001060 000280e7 00004000 1 0 f 1 f
00001064 0040006f 00001068 1 0 f 1 f
00001068 00000013 0000106c 0 0 f 0 f
0000106c 0000a103 00001070 0 1 1 3 1
00001070 00000097 00001074 0 0 f 0 f
00001074 000020b7 00001078 0 0 f 0 f

// File: compile.f
expipe_pkg.sv
iq_storage.sv
issue_queue.sv
issue_dispatch.sv
issue_stage.sv
tb_issue_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f compile.f \
    --top-module tb_issue_stage \
    -o sim_issue_stage

# A failing run stops through $fatal, the search below decides the result
output=$(./obj_dir/sim_issue_stage 2>&1 || true)
echo "$output"

if grep -q "Verification passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
